//--- snn_core.f
source/snn_pkg.sv
source/snn_bus_pkg.sv
source/snn_wb_regs.sv
source/snn_ram.sv
source/snn_spike_gen.sv
source/snn_spike_queue.sv
source/snn_lif_neuron.sv
source/snn_controller.sv
source/snn_core_top.sv
testbench/snn_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= snn_core_tb
FILELIST  ?= snn_core.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal
PASS_MSG  ?= Testbench passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- testbench/snn_core_tb.sv
`timescale 1ns/1ps

module snn_core_tb;
    localparam int ACK_TIMEOUT  = 20;
    localparam int DONE_TIMEOUT = 100000;                     // cycles per inference

    logic                 clk;
    logic                 rst;
    snn_bus_pkg::wb_req_t wb_req;
    snn_bus_pkg::wb_rsp_t wb_rsp;
    logic                 done;
    int                   seed;
    int                   errors;
    int                   checks;
    string                test_name;
    snn_pkg::pixel_t      image [snn_pkg::NUM_PIXELS];
    snn_pkg::weight_t     weights [snn_pkg::NUM_WEIGHTS];
    int                   exp_counts [snn_pkg::NUM_NEURONS];
    int                   cur_beta;
    int                   cur_vth;
    int                   cur_steps;

    snn_core_top i_dut (
        .clk(clk), .rst(rst), .wb_req_i(wb_req), .wb_rsp_o(wb_rsp), .done_o(done)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    task automatic finish_run();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        errors++;
        finish_run();
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("error in %s: %s expected %0d actual %0d", test_name, what, expected, actual);
        end
    endtask

    function automatic logic [31:0] reg_addr(input logic [15:0] ofs, input int index);
        return snn_bus_pkg::WB_BASE + {16'h0, ofs} + 32'(index * 4);
    endfunction

    // one bus request with its ack checks
    task automatic wb_access(input logic we, input logic [31:0] adr, input logic [31:0] wdata,
                             output logic [31:0] rdata);
        int waited;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.sel = 4'hF;
        wb_req.adr = adr;
        wb_req.dat = wdata;
        waited = 1;
        @(negedge clk);
        while (!wb_rsp.ack && waited < ACK_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!wb_rsp.ack) begin
            abort_run($sformatf("no Wishbone ack for address 0x%08h", adr));
        end else begin
            rdata  = wb_rsp.dat;
            wb_req = '0;
            check_value("ack latency in cycles", 32'd1, waited);
            @(negedge clk);
            check_value("ack after release", 32'd0, {31'h0, wb_rsp.ack});   // exactly one ack
        end
    endtask

    task automatic wb_write(input logic [31:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        wb_access(1'b1, adr, data, unused);
    endtask

    task automatic wb_read(input logic [31:0] adr, output logic [31:0] data);
        wb_access(1'b0, adr, 32'h0, data);
    endtask

    task automatic wait_done();
        int waited;
        waited = 0;
        while (!done && waited < DONE_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!done) abort_run("inference never raised done");
    endtask

    task automatic set_params(input int beta, input int v_th, input int steps);
        logic [31:0] word;
        cur_beta  = beta;
        cur_vth   = v_th;
        cur_steps = steps;
        word = {8'h00, steps[7:0], v_th[7:0], beta[7:0]};
        wb_write(reg_addr(snn_bus_pkg::PARAM_OFS, 0), word);
    endtask

    task automatic load_image();
        for (int p = 0; p < snn_pkg::NUM_PIXELS; p++) begin
            wb_write(reg_addr(snn_bus_pkg::IMAGE_OFS, p), {24'h0, image[p]});
        end
    endtask

    task automatic load_weights(input int first_pix, input int last_pix);
        for (int i = first_pix * snn_pkg::NUM_NEURONS;
             i < (last_pix + 1) * snn_pkg::NUM_NEURONS; i++) begin
            wb_write(reg_addr(snn_bus_pkg::WEIGHT_OFS, i), {24'h0, weights[i]});
        end
    endtask

    task automatic start_inference();
        wb_write(reg_addr(snn_bus_pkg::CTRL_OFS, 0), 32'h1);
        wait_done();
    endtask

    // lit pixels of 255 spike in every step
    task automatic model_counts();
        int v [snn_pkg::NUM_NEURONS];
        for (int n = 0; n < snn_pkg::NUM_NEURONS; n++) begin
            v[n] = 0;
            exp_counts[n] = 0;
        end
        for (int s = 0; s < cur_steps; s++) begin
            for (int p = 0; p < snn_pkg::NUM_PIXELS; p++) begin
                if (image[p] != 8'h00) begin
                    for (int n = 0; n < snn_pkg::NUM_NEURONS; n++) begin
                        v[n] = v[n] + int'(weights[p * snn_pkg::NUM_NEURONS + n]);
                        if (v[n] > 127) v[n] = 127;
                        else if (v[n] < -128) v[n] = -128;
                    end
                end
            end
            for (int n = 0; n < snn_pkg::NUM_NEURONS; n++) begin
                if (v[n] >= cur_vth) begin
                    v[n] = 0;
                    if (exp_counts[n] < 255) exp_counts[n]++;
                end else begin
                    v[n] = (v[n] * cur_beta) >>> 8;
                end
            end
        end
    endtask

    task automatic check_counts(input string what);
        logic [31:0] word;
        for (int n = 0; n < snn_pkg::NUM_NEURONS; n++) begin
            wb_read(reg_addr(snn_bus_pkg::COUNT_OFS, n), word);
            check_value($sformatf("%s count of neuron %0d", what, n), exp_counts[n], word);
        end
    endtask

    task automatic test_registers();
        logic [31:0] word;
        test_name = "register access";
        wb_read(reg_addr(snn_bus_pkg::CTRL_OFS, 0), word);
        check_value("CTRL after reset", 32'h0, word);
        wb_read(reg_addr(snn_bus_pkg::PARAM_OFS, 0), word);
        check_value("PARAM after reset", 32'h0, word);
        set_params(8'h19, 8'hC8, 4);
        wb_read(reg_addr(snn_bus_pkg::PARAM_OFS, 0), word);
        check_value("PARAM readback", 32'h0004_C819, word);
        wb_read(reg_addr(16'h0800, 0), word);                 // hole in the map
        check_value("unmapped offset", 32'h0, word);
        wb_read(32'h2000_0000, word);
        check_value("address outside base", 32'h0, word);
        for (int n = 0; n < snn_pkg::NUM_NEURONS; n++) exp_counts[n] = 0;
        check_counts("after reset");
    endtask

    task automatic test_zero_image();
        logic [31:0] word;
        test_name = "all-zero image";
        foreach (image[p]) image[p] = 8'h00;
        foreach (weights[i]) weights[i] = 8'sd100;            // any stray spike would fire
        load_image();
        load_weights(0, snn_pkg::NUM_PIXELS - 1);
        set_params(200, 10, 3);
        start_inference();
        check_value("done level", 32'd1, {31'h0, done});
        wb_read(reg_addr(snn_bus_pkg::CTRL_OFS, 0), word);
        check_value("CTRL when done", 32'h2, word);
        for (int n = 0; n < snn_pkg::NUM_NEURONS; n++) exp_counts[n] = 0;
        check_counts("zero image");
    endtask

    task automatic test_single_pixel();
        int picks [snn_pkg::NUM_NEURONS];
        test_name = "single pixel";
        // neuron 1 and 6 need several integrating steps before they fire
        picks = '{50, 20, -30, 127, 0, 45, 10, 39, 40, -128};
        image[37] = 8'hFF;
        for (int n = 0; n < snn_pkg::NUM_NEURONS; n++) begin
            weights[37 * snn_pkg::NUM_NEURONS + n] = picks[n][7:0];
        end
        load_image();
        load_weights(37, 37);
        set_params(240, 40, 6);
        start_inference();
        model_counts();
        check_counts("single pixel");
    endtask

    task automatic test_saturation();
        int lit [5];
        test_name = "saturation";
        lit = '{0, 50, 100, 150, 195};
        foreach (image[p]) image[p] = 8'h00;
        foreach (lit[k]) begin
            image[lit[k]] = 8'hFF;
            for (int n = 0; n < snn_pkg::NUM_NEURONS; n++) begin
                weights[lit[k] * snn_pkg::NUM_NEURONS + n] = 8'sd127;
            end
        end
        load_image();
        foreach (lit[k]) load_weights(lit[k], lit[k]);
        set_params(128, 127, 5);
        start_inference();
        for (int n = 0; n < snn_pkg::NUM_NEURONS; n++) exp_counts[n] = 5;  // one spike per step
        check_counts("saturated");
    endtask

    task automatic test_random_image();
        int rnd;
        test_name = "random image";
        foreach (image[p]) begin
            rnd = $random(seed);
            image[p] = rnd[0] ? 8'hFF : 8'h00;
        end
        foreach (weights[i]) begin
            rnd = $random(seed) % 40;
            weights[i] = rnd[7:0];
        end
        load_image();
        load_weights(0, snn_pkg::NUM_PIXELS - 1);
        set_params(200, 60, 4);
        start_inference();
        model_counts();
        check_counts("first run");
        start_inference();                                    // no reload in between
        check_counts("second run");
    endtask

    task automatic test_busy_writes();
        logic [31:0] param_exp;
        logic [31:0] word;
        test_name = "writes while busy";
        param_exp = {8'h00, cur_steps[7:0], cur_vth[7:0], cur_beta[7:0]};
        wb_write(reg_addr(snn_bus_pkg::CTRL_OFS, 0), 32'h1);
        wb_read(reg_addr(snn_bus_pkg::CTRL_OFS, 0), word);
        check_value("CTRL while running", 32'h1, word);
        wb_write(reg_addr(snn_bus_pkg::PARAM_OFS, 0), 32'h0001_7F00);
        for (int p = 0; p < 10; p++) begin
            wb_write(reg_addr(snn_bus_pkg::IMAGE_OFS, p), {24'h0, ~image[p]});
        end
        wait_done();
        check_counts("during busy writes");
        wb_read(reg_addr(snn_bus_pkg::PARAM_OFS, 0), word);
        check_value("PARAM after busy write", param_exp, word);
        start_inference();                                    // image must be untouched
        check_counts("rerun after busy writes");
    endtask

    initial begin
        seed      = 32'h1128_d996;
        errors    = 0;
        checks    = 0;
        test_name = "reset";
        wb_req    = '0;
        rst       = 1'b1;
        foreach (image[p]) image[p] = 8'h00;
        foreach (weights[i]) weights[i] = 8'sd0;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        test_registers();
        test_zero_image();
        test_single_pixel();
        test_saturation();
        test_random_image();
        test_busy_writes();
        finish_run();
    end

endmodule

//--- source/snn_core_top.sv
`timescale 1ns/1ps

module snn_core_top (
    input  logic                 clk,
    input  logic                 rst,
    input  snn_bus_pkg::wb_req_t wb_req_i,
    output snn_bus_pkg::wb_rsp_t wb_rsp_o,
    output logic                 done_o
);
    snn_pkg::neuron_cfg_t             cfg;
    snn_pkg::count_t                  counts [snn_pkg::NUM_NEURONS];
    logic                             start;
    logic                             busy;
    logic                             img_we;
    logic [snn_pkg::PIXEL_IDX_W-1:0]   img_waddr;
    logic [snn_pkg::PIXEL_IDX_W-1:0]   img_raddr;
    snn_pkg::pixel_t                  img_wdata;
    snn_pkg::pixel_t                  img_rdata;
    logic                             wt_we;
    logic [snn_pkg::WEIGHT_ADDR_W-1:0] wt_waddr;
    logic [snn_pkg::WEIGHT_ADDR_W-1:0] wt_raddr;
    snn_pkg::weight_t                 wt_wdata;
    snn_pkg::weight_t                 wt_rdata;
    logic                             pixel_vld;
    logic [snn_pkg::PIXEL_IDX_W-1:0]   pixel_idx;
    logic                             reseed;
    logic                             queue_clear;
    logic                             push;
    logic [snn_pkg::PIXEL_IDX_W-1:0]   push_idx;
    logic                             pop;
    logic [snn_pkg::PIXEL_IDX_W-1:0]   head_idx;
    logic                             not_empty;
    snn_pkg::neuron_op_t              neuron_op;
    snn_pkg::vmem_t                   neuron_vmem;
    logic                             neuron_fire;

    snn_wb_regs i_regs (
        .clk(clk), .rst(rst), .wb_req_i(wb_req_i), .busy_i(busy), .done_i(done_o),
        .counts_i(counts), .wb_rsp_o(wb_rsp_o), .cfg_o(cfg), .start_o(start),
        .img_we_o(img_we), .img_addr_o(img_waddr), .img_data_o(img_wdata),
        .wt_we_o(wt_we), .wt_addr_o(wt_waddr), .wt_data_o(wt_wdata)
    );

    snn_ram #(.DEPTH(snn_pkg::NUM_PIXELS), .WIDTH(8)) i_image_ram (
        .clk(clk), .we_i(img_we), .waddr_i(img_waddr), .wdata_i(img_wdata),
        .raddr_i(img_raddr), .rdata_o(img_rdata)
    );

    snn_ram #(.DEPTH(snn_pkg::NUM_WEIGHTS), .WIDTH(8)) i_weight_ram (
        .clk(clk), .we_i(wt_we), .waddr_i(wt_waddr), .wdata_i(wt_wdata),
        .raddr_i(wt_raddr), .rdata_o(wt_rdata)
    );

    snn_spike_gen i_spike_gen (
        .clk(clk), .rst(rst), .reseed_i(reseed), .pixel_vld_i(pixel_vld),
        .pixel_idx_i(pixel_idx), .pixel_i(img_rdata), .push_o(push), .push_idx_o(push_idx)
    );

    snn_spike_queue i_queue (
        .clk(clk), .rst(rst), .clear_i(queue_clear), .push_i(push), .push_idx_i(push_idx),
        .pop_i(pop), .head_idx_o(head_idx), .not_empty_o(not_empty)
    );

    snn_controller i_ctrl (
        .clk(clk), .rst(rst), .start_i(start), .cfg_i(cfg), .img_data_i(img_rdata),
        .not_empty_i(not_empty), .head_idx_i(head_idx), .wt_data_i(wt_rdata),
        .neuron_vmem_i(neuron_vmem), .neuron_fire_i(neuron_fire), .img_addr_o(img_raddr),
        .pixel_vld_o(pixel_vld), .pixel_idx_o(pixel_idx), .reseed_o(reseed),
        .queue_clear_o(queue_clear), .pop_o(pop), .wt_addr_o(wt_raddr),
        .neuron_op_o(neuron_op), .busy_o(busy), .done_o(done_o), .counts_o(counts)
    );

    snn_lif_neuron i_neuron (
        .op_i(neuron_op), .v_th_i(cfg.v_th), .beta_i(cfg.beta),
        .vmem_o(neuron_vmem), .fire_o(neuron_fire)
    );

endmodule

//--- source/snn_controller.sv
`timescale 1ns/1ps

module snn_controller (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               start_i,
    input  snn_pkg::neuron_cfg_t               cfg_i,
    input  snn_pkg::pixel_t                    img_data_i,
    input  logic                               not_empty_i,
    input  logic [snn_pkg::PIXEL_IDX_W-1:0]   head_idx_i,
    input  snn_pkg::weight_t                   wt_data_i,
    input  snn_pkg::vmem_t                     neuron_vmem_i,
    input  logic                               neuron_fire_i,
    output logic [snn_pkg::PIXEL_IDX_W-1:0]   img_addr_o,
    output logic                               pixel_vld_o,
    output logic [snn_pkg::PIXEL_IDX_W-1:0]   pixel_idx_o,
    output logic                               reseed_o,
    output logic                               queue_clear_o,
    output logic                               pop_o,
    output logic [snn_pkg::WEIGHT_ADDR_W-1:0] wt_addr_o,
    output snn_pkg::neuron_op_t                neuron_op_o,
    output logic                               busy_o,
    output logic                               done_o,
    output snn_pkg::count_t                    counts_o [snn_pkg::NUM_NEURONS]
);
    typedef enum logic [2:0] {
        IDLE, GEN_SPIKES, LOAD_SPIKE, INTEGRATE, LEAK_FIRE, CHECK_END
    } state_t;

    state_t                           state;
    logic [snn_pkg::PIXEL_IDX_W-1:0]  pix_cnt;
    logic [snn_pkg::PIXEL_IDX_W-1:0]  spk_idx;
    logic [snn_pkg::PIXEL_IDX_W-1:0]  wt_pix;
    logic [snn_pkg::NEURON_IDX_W-1:0] nrn;
    logic [snn_pkg::NEURON_IDX_W-1:0] wt_nrn;
    logic [7:0]                       step;
    logic                             pix_vld_q;
    logic                             last_nrn;
    logic                             last_step;
    int                               wt_lin;
    snn_pkg::vmem_t                   vmem [snn_pkg::NUM_NEURONS];

    assign busy_o        = state != IDLE;
    assign reseed_o      = start_i;
    assign last_nrn      = int'(nrn) == snn_pkg::NUM_NEURONS - 1;
    assign last_step     = step == cfg_i.num_steps - 8'd1;
    assign queue_clear_o = (state == IDLE && start_i) || (state == CHECK_END && !last_step);
    assign pop_o         = state == LOAD_SPIKE && not_empty_i;

    // black pixels never spike, no strobe for them
    assign img_addr_o  = pix_cnt;
    assign pixel_vld_o = pix_vld_q && img_data_i != '0;

    // neuron 0 is addressed while popping, then one ahead
    assign wt_pix    = (state == LOAD_SPIKE) ? head_idx_i : spk_idx;
    assign wt_nrn    = (state == LOAD_SPIKE) ? '0 : nrn + 1'b1;
    assign wt_lin    = int'(wt_pix) * snn_pkg::NUM_NEURONS + int'(wt_nrn);
    assign wt_addr_o = wt_lin[snn_pkg::WEIGHT_ADDR_W-1:0];

    assign neuron_op_o.op_leak = state == LEAK_FIRE;
    assign neuron_op_o.vmem    = vmem[nrn];
    assign neuron_op_o.weight  = wt_data_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            pix_cnt   <= '0;
            nrn       <= '0;
            step      <= '0;
            pix_vld_q <= 1'b0;
            done_o    <= 1'b0;
            for (int n = 0; n < snn_pkg::NUM_NEURONS; n++) counts_o[n] <= '0;
        end else begin
            pix_vld_q <= state == GEN_SPIKES && int'(pix_cnt) < snn_pkg::NUM_PIXELS;
            case (state)
                IDLE: if (start_i) begin
                    state  <= GEN_SPIKES;
                    done_o <= 1'b0;
                    step   <= '0;
                    for (int n = 0; n < snn_pkg::NUM_NEURONS; n++) counts_o[n] <= '0;
                end
                GEN_SPIKES: begin
                    pix_cnt <= pix_cnt + 1'b1;
                    if (int'(pix_cnt) == snn_pkg::NUM_PIXELS + 1) begin  // last push landed
                        pix_cnt <= '0;
                        state   <= LOAD_SPIKE;
                    end
                end
                LOAD_SPIKE: state <= not_empty_i ? INTEGRATE : LEAK_FIRE;
                INTEGRATE: begin
                    nrn <= nrn + 1'b1;
                    if (last_nrn) begin
                        nrn   <= '0;
                        state <= LOAD_SPIKE;
                    end
                end
                LEAK_FIRE: begin
                    if (neuron_fire_i && counts_o[nrn] != 8'hFF) begin
                        counts_o[nrn] <= counts_o[nrn] + 1'b1;
                    end
                    nrn <= nrn + 1'b1;
                    if (last_nrn) begin
                        nrn   <= '0;
                        state <= CHECK_END;
                    end
                end
                CHECK_END: begin
                    if (last_step) begin
                        done_o <= 1'b1;                       // held until next start
                        state  <= IDLE;
                    end else begin
                        step  <= step + 1'b1;
                        state <= GEN_SPIKES;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        pixel_idx_o <= pix_cnt;
        if (pop_o) spk_idx <= head_idx_i;
        if (state == IDLE && start_i) begin
            for (int n = 0; n < snn_pkg::NUM_NEURONS; n++) vmem[n] <= '0;
        end else if (state == INTEGRATE || state == LEAK_FIRE) begin
            vmem[nrn] <= neuron_vmem_i;
        end
    end

endmodule

//--- source/snn_lif_neuron.sv
`timescale 1ns/1ps

module snn_lif_neuron (
    input  snn_pkg::neuron_op_t op_i,
    input  snn_pkg::vmem_t      v_th_i,
    input  logic [7:0]          beta_i,
    output snn_pkg::vmem_t      vmem_o,
    output logic                fire_o
);
    logic signed [8:0] sum;
    logic [16:0]       prod;

    assign sum = {op_i.vmem[7], op_i.vmem} + {op_i.weight[7], op_i.weight};
    // low 17 bits of the product are sign-correct
    assign prod = {{9{op_i.vmem[7]}}, op_i.vmem} * {9'h000, beta_i};

    always_comb begin
        fire_o = 1'b0;
        if (!op_i.op_leak) begin
            if (sum[8] != sum[7]) begin
                vmem_o = sum[8] ? 8'sh80 : 8'sh7F;            // clamp on overflow
            end else begin
                vmem_o = sum[7:0];
            end
        end else if (op_i.vmem >= v_th_i) begin
            fire_o = 1'b1;
            vmem_o = '0;                                      // reset to zero on fire
        end else begin
            vmem_o = prod[15:8];                              // vmem*beta >>> 8 fits 8 bits
        end
    end

endmodule

//--- source/snn_spike_queue.sv
`timescale 1ns/1ps

module snn_spike_queue (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             clear_i,
    input  logic                             push_i,
    input  logic [snn_pkg::PIXEL_IDX_W-1:0] push_idx_i,
    input  logic                             pop_i,
    output logic [snn_pkg::PIXEL_IDX_W-1:0] head_idx_o,
    output logic                             not_empty_o
);
    logic [snn_pkg::PIXEL_IDX_W-1:0]          mem [snn_pkg::QUEUE_DEPTH];
    logic [$clog2(snn_pkg::QUEUE_DEPTH)-1:0] wr_ptr;
    logic [$clog2(snn_pkg::QUEUE_DEPTH)-1:0] rd_ptr;
    logic [$clog2(snn_pkg::QUEUE_DEPTH):0]   count;
    logic                                     do_pop;

    assign not_empty_o = count != '0;
    assign do_pop      = pop_i && not_empty_o;
    assign head_idx_o  = mem[rd_ptr];                         // first-word fall-through

    always_ff @(posedge clk) begin
        if (rst || clear_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) wr_ptr <= wr_ptr + 1'b1;              // pointers wrap at depth
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            if (push_i && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !push_i) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) mem[wr_ptr] <= push_idx_i;
    end

endmodule

//--- source/snn_spike_gen.sv
`timescale 1ns/1ps

module snn_spike_gen (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             reseed_i,
    input  logic                             pixel_vld_i,
    input  logic [snn_pkg::PIXEL_IDX_W-1:0] pixel_idx_i,
    input  snn_pkg::pixel_t                  pixel_i,
    output logic                             push_o,
    output logic [snn_pkg::PIXEL_IDX_W-1:0] push_idx_o
);
    logic [7:0] lfsr;
    logic       feedback;
    logic       spike;

    assign feedback = ^(lfsr & snn_pkg::LFSR_TAPS);
    // brighter pixels spike more often
    assign spike = pixel_i != '0 && pixel_i >= lfsr;

    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr   <= snn_pkg::LFSR_SEED;
            push_o <= 1'b0;
        end else begin
            if (reseed_i) begin
                lfsr <= snn_pkg::LFSR_SEED;                   // same sequence every inference
            end else if (pixel_vld_i) begin
                lfsr <= {lfsr[6:0], feedback};
            end
            push_o <= pixel_vld_i && spike;
        end
    end

    always_ff @(posedge clk) begin
        push_idx_o <= pixel_idx_i;
    end

endmodule

//--- source/snn_ram.sv
`timescale 1ns/1ps

module snn_ram #(
    parameter int DEPTH = 256,
    parameter int WIDTH = 8
) (
    input  logic                     clk,
    input  logic                     we_i,
    input  logic [$clog2(DEPTH)-1:0] waddr_i,
    input  logic [WIDTH-1:0]         wdata_i,
    input  logic [$clog2(DEPTH)-1:0] raddr_i,
    output logic [WIDTH-1:0]         rdata_o
);
    logic [WIDTH-1:0] mem [DEPTH];

    // one write port, one registered read port
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
        rdata_o <= mem[raddr_i];                              // one cycle latency
    end

endmodule

//--- source/snn_wb_regs.sv
`timescale 1ns/1ps

module snn_wb_regs (
    input  logic                               clk,
    input  logic                               rst,
    input  snn_bus_pkg::wb_req_t               wb_req_i,
    input  logic                               busy_i,
    input  logic                               done_i,
    input  snn_pkg::count_t                    counts_i [snn_pkg::NUM_NEURONS],
    output snn_bus_pkg::wb_rsp_t               wb_rsp_o,
    output snn_pkg::neuron_cfg_t               cfg_o,
    output logic                               start_o,
    output logic                               img_we_o,
    output logic [snn_pkg::PIXEL_IDX_W-1:0]   img_addr_o,
    output snn_pkg::pixel_t                    img_data_o,
    output logic                               wt_we_o,
    output logic [snn_pkg::WEIGHT_ADDR_W-1:0] wt_addr_o,
    output snn_pkg::weight_t                   wt_data_o
);
    logic                   req;
    logic                   hit;
    logic                   wr;
    logic [15:0]            ofs;
    logic [15:0]            img_rel;
    logic [15:0]            wt_rel;
    logic [15:0]            cnt_rel;
    logic                   img_hit;
    logic                   wt_hit;
    logic                   cnt_hit;
    logic                   ack_q;
    logic [31:0]            dat_q;
    logic [31:0]            rd_dat;
    snn_bus_pkg::bus_word_u wr_word;
    snn_bus_pkg::bus_word_u rd_word;

    assign req = wb_req_i.cyc && wb_req_i.stb && !ack_q;     // one ack per request
    assign ofs = wb_req_i.adr[15:0];
    assign hit = ((wb_req_i.adr & 32'hFFFF_0000) == snn_bus_pkg::WB_BASE) && ofs[1:0] == 2'b00;
    assign wr  = req && hit && wb_req_i.we && !busy_i;        // writes dropped mid inference
    assign wr_word = wb_req_i.dat;

    // below-window offsets wrap to large indices
    assign img_rel = ofs - snn_bus_pkg::IMAGE_OFS;
    assign wt_rel  = ofs - snn_bus_pkg::WEIGHT_OFS;
    assign cnt_rel = ofs - snn_bus_pkg::COUNT_OFS;
    assign img_hit = hit && int'(img_rel[15:2]) < snn_pkg::NUM_PIXELS;
    assign wt_hit  = hit && int'(wt_rel[15:2]) < snn_pkg::NUM_WEIGHTS;
    assign cnt_hit = hit && int'(cnt_rel[15:2]) < snn_pkg::NUM_NEURONS;

    assign wb_rsp_o.ack = ack_q;
    assign wb_rsp_o.dat = dat_q;

    always_comb begin
        rd_word = '0;
        rd_dat  = '0;
        if (hit && ofs == snn_bus_pkg::CTRL_OFS) begin
            rd_word.ctrl.go   = busy_i;
            rd_word.ctrl.done = done_i;
            rd_dat            = rd_word;
        end else if (hit && ofs == snn_bus_pkg::PARAM_OFS) begin
            rd_word.param.cfg = cfg_o;
            rd_dat            = rd_word;
        end else if (cnt_hit) begin
            rd_dat = {24'h0, counts_i[cnt_rel[2 +: snn_pkg::NEURON_IDX_W]]};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q    <= 1'b0;
            start_o  <= 1'b0;
            img_we_o <= 1'b0;
            wt_we_o  <= 1'b0;
            cfg_o    <= '0;
        end else begin
            ack_q    <= req;
            start_o  <= wr && ofs == snn_bus_pkg::CTRL_OFS && wb_req_i.sel[0] && wr_word.ctrl.go;
            img_we_o <= wr && img_hit && wb_req_i.sel[0];
            wt_we_o  <= wr && wt_hit && wb_req_i.sel[0];
            if (wr && ofs == snn_bus_pkg::PARAM_OFS) begin
                if (wb_req_i.sel[0]) cfg_o.beta <= wr_word.param.cfg.beta;
                if (wb_req_i.sel[1]) cfg_o.v_th <= wr_word.param.cfg.v_th;
                if (wb_req_i.sel[2]) cfg_o.num_steps <= wr_word.param.cfg.num_steps;
            end
        end
    end

    // read data and memory write payload
    always_ff @(posedge clk) begin
        dat_q      <= rd_dat;
        img_addr_o <= img_rel[2 +: snn_pkg::PIXEL_IDX_W];
        img_data_o <= wb_req_i.dat[7:0];
        wt_addr_o  <= wt_rel[2 +: snn_pkg::WEIGHT_ADDR_W];
        wt_data_o  <= wb_req_i.dat[7:0];
    end

endmodule

//--- source/snn_bus_pkg.sv
package snn_bus_pkg;

    localparam logic [31:0] WB_BASE = 32'h3000_0000;

    // register map, byte offsets from WB_BASE
    localparam logic [15:0] CTRL_OFS   = 16'h0000;
    localparam logic [15:0] PARAM_OFS  = 16'h0004;
    localparam logic [15:0] COUNT_OFS  = 16'h0100;            // one word per neuron
    localparam logic [15:0] IMAGE_OFS  = 16'h1000;            // one word per pixel
    localparam logic [15:0] WEIGHT_OFS = 16'h4000;            // pixel*10 + neuron

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  sel;
        logic [31:0] adr;
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    typedef struct packed {
        logic [29:0] rsvd;
        logic        done;                                    // read only
        logic        go;                                      // start on write, busy on read
    } ctrl_word_t;

    typedef struct packed {
        logic [7:0]           rsvd;
        snn_pkg::neuron_cfg_t cfg;
    } param_word_t;

    // offset picks the view
    typedef union packed {
        ctrl_word_t  ctrl;
        param_word_t param;
    } bus_word_u;

endpackage

//--- source/snn_pkg.sv
package snn_pkg;

    // network dimensions
    localparam int NUM_PIXELS    = 196;                       // 14x14 image
    localparam int NUM_NEURONS   = 10;
    localparam int NUM_WEIGHTS   = NUM_PIXELS * NUM_NEURONS;
    localparam int PIXEL_IDX_W   = 8;
    localparam int WEIGHT_ADDR_W = 11;
    localparam int NEURON_IDX_W  = 4;
    localparam int QUEUE_DEPTH   = 256;                       // room for every pixel

    // rate encoder LFSR
    localparam logic [7:0] LFSR_SEED = 8'hA5;
    localparam logic [7:0] LFSR_TAPS = 8'hB8;                 // x^8+x^6+x^5+x^4+1

    typedef logic [7:0]        pixel_t;                       // unsigned intensity
    typedef logic signed [7:0] weight_t;
    typedef logic signed [7:0] vmem_t;
    typedef logic [7:0]        count_t;

    // field order matches the PARAM register bytes
    typedef struct packed {
        logic [7:0] num_steps;                                // timesteps, 1 or more
        vmem_t      v_th;
        logic [7:0] beta;                                     // leak in 256ths
    } neuron_cfg_t;

    typedef struct packed {
        logic    op_leak;                                     // 0 integrate, 1 leak and fire
        vmem_t   vmem;
        weight_t weight;
    } neuron_op_t;

endpackage
